//--- source/cmult_pkg.sv
// Shared widths, multiplier latency and complex word types, imported by every design unit

package cmult_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  // One real or imaginary part, Q1.15
  localparam int DATA_W = 16;
  // Full signed product, Q2.30
  localparam int PROD_W = 2 * DATA_W;
  // Lane sum, one guard bit so a +/- of two products cannot wrap
  localparam int SUM_W  = PROD_W + 1;

  // ------------------------------
  // Multiplier latency
  // ------------------------------
  // Cycles from core operands to core product, must be >= 1
  localparam int LATENCY = 3;

  // Number of delay stages the multiplier core is built with
  // Keep in step with LATENCY, the core stops elaboration otherwise
  function automatic int get_latency();
    return 3;
  endfunction

  // ------------------------------
  // Complex word
  // ------------------------------
  typedef logic signed [DATA_W-1:0] cplx_part_t;

  // Real part in the upper half, imaginary part in the lower half
  typedef struct packed {
    cplx_part_t re;
    cplx_part_t im;
  } cplx_fields_t;

  // Same 32 bits seen as a bus or as two parts
  typedef union packed {
    logic [2*DATA_W-1:0] raw;
    cplx_fields_t        fields;
  } cplx_word_u;

endpackage

//--- source/arith_mult_core.sv
// Pipelined signed multiplier z = a * b, latency taken from the package, used by each lane

`timescale 1ns/10ps

module arith_mult_core
  import cmult_pkg::*;
#(
  parameter bit IN_PIPE = 0,
  parameter int OP_A_W  = 16,
  parameter int OP_B_W  = 16
) (
  input  logic                              clk,
  input  logic signed [OP_A_W-1:0]          a,
  input  logic signed [OP_B_W-1:0]          b,
  output logic signed [OP_A_W+OP_B_W-1:0]   z
);

  localparam int PROD_BITS = OP_A_W + OP_B_W;

  // ------------------------------
  // Elaboration checks
  // ------------------------------
  if (LATENCY < 1) begin : g_bad_latency
    $fatal(1, "arith_mult_core: LATENCY must be at least 1, got %0d", LATENCY);
  end

  if (get_latency() != LATENCY) begin : g_latency_mismatch
    $fatal(1, "arith_mult_core: get_latency()=%0d differs from LATENCY=%0d",
           get_latency(), LATENCY);
  end

  // ------------------------------
  // Optional input register
  // ------------------------------
  logic signed [OP_A_W-1:0] s0_a;
  logic signed [OP_B_W-1:0] s0_b;

  if (IN_PIPE) begin : g_in_pipe
    always_ff @(posedge clk) begin
      s0_a <= a;
      s0_b <= b;
    end
  end else begin : g_no_in_pipe
    assign s0_a = a;
    assign s0_b = b;
  end

  // Signed product, both operands signed so extension is arithmetic
  logic signed [PROD_BITS-1:0] s0_prod;
  assign s0_prod = s0_a * s0_b;

  // ------------------------------
  // Delay line
  // ------------------------------
  // Plain registers after the multiply, retimed into the DSP by synthesis
  logic signed [PROD_BITS-1:0] prod_dly [LATENCY];

  always_ff @(posedge clk) begin
    prod_dly[0] <= s0_prod;
    for (int i = 1; i < LATENCY; i++) begin
      prod_dly[i] <= prod_dly[i-1];
    end
  end

  // Last stage is the product
  assign z = prod_dly[LATENCY-1];

endmodule

//--- source/cmult_operand_if.sv
// Operand bundle from the top level to the two lanes and the valid strobe to the combiner

`timescale 1ns/10ps

interface cmult_operand_if
  import cmult_pkg::*;
();

  // Operand a parts
  cplx_part_t a_re;
  cplx_part_t a_im;
  // Operand b parts
  cplx_part_t b_re;
  cplx_part_t b_im;
  // Sample strobe, one cycle per operand pair
  logic       valid;

  // Lane side, data only
  modport lane (input a_re, input a_im, input b_re, input b_im);

  // Combiner side, strobe only
  modport ctrl (input valid);

endinterface

//--- source/cmult_lane.sv
// One complex multiplier lane: x0*y0 +/- x1*y1 with a registered sum, instanced per output part

`timescale 1ns/10ps

module cmult_lane
  import cmult_pkg::*;
#(
  parameter bit SUBTRACT = 0,
  parameter bit IN_PIPE  = 0,
  parameter int OP_W     = 16
) (
  input  logic                    clk,
  input  cplx_part_t              x0,
  input  cplx_part_t              y0,
  input  cplx_part_t              x1,
  input  cplx_part_t              y1,
  input  logic                    valid,
  output logic signed [SUM_W-1:0] sum
);

  // ------------------------------
  // Products
  // ------------------------------
  logic signed [2*OP_W-1:0] prod0;
  logic signed [2*OP_W-1:0] prod1;

  // First product term
  arith_mult_core #(
    .IN_PIPE (IN_PIPE),
    .OP_A_W  (OP_W),
    .OP_B_W  (OP_W)
  ) mult0 (
    .clk (clk),
    .a   (x0),
    .b   (y0),
    .z   (prod0)
  );

  // Second product term, same pipeline depth
  arith_mult_core #(
    .IN_PIPE (IN_PIPE),
    .OP_A_W  (OP_W),
    .OP_B_W  (OP_W)
  ) mult1 (
    .clk (clk),
    .a   (x1),
    .b   (y1),
    .z   (prod1)
  );

  // ------------------------------
  // Add / subtract stage
  // ------------------------------
  // One extra bit of headroom, sign extended before the add
  always_ff @(posedge clk) begin
    if (SUBTRACT) begin
      sum <= SUM_W'(prod0) - SUM_W'(prod1);
    end else begin
      sum <= SUM_W'(prod0) + SUM_W'(prod1);
    end
  end

  // Strobe comes from the top level, operands must be clean on a live sample
  a_operands_known : assert property (
    @(posedge clk) valid |-> !$isunknown({x0, y0, x1, y1})
  ) else $error("cmult_lane: unknown operand bits on a valid sample");

endmodule

//--- source/cmult_round.sv
// Output combiner: valid alignment, Q2.30 to Q1.15 round and clamp, result word register

`timescale 1ns/10ps

module cmult_round
  import cmult_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  cmult_operand_if.ctrl           ops,
  input  logic signed [SUM_W-1:0] re_sum,
  input  logic signed [SUM_W-1:0] im_sum,
  output cplx_word_u              res_word,
  output logic                    out_valid
);

  // Width after dropping DATA_W-1 fraction bits
  localparam int SHR_W = SUM_W - DATA_W + 1;

  // Half an output LSB in Q2.30
  localparam logic signed [SUM_W-1:0] ROUND_BIAS = SUM_W'(1) <<< (DATA_W - 2);

  // Clamp limits of a Q1.15 part
  localparam logic signed [SHR_W-1:0] PART_MAX = SHR_W'((1 << (DATA_W - 1)) - 1);
  localparam logic signed [SHR_W-1:0] PART_MIN = -SHR_W'(1 << (DATA_W - 1));

  // ------------------------------
  // Round and saturate
  // ------------------------------
  // Ties round toward +inf
  function automatic cplx_part_t round_sat(input logic signed [SUM_W-1:0] s);
    logic signed [SUM_W-1:0] biased;
    logic signed [SHR_W-1:0] shifted;
    biased  = s + ROUND_BIAS;
    shifted = biased[SUM_W-1:DATA_W-1];
    if (shifted > PART_MAX) begin
      return PART_MAX[DATA_W-1:0];
    end else if (shifted < PART_MIN) begin
      return PART_MIN[DATA_W-1:0];
    end
    return shifted[DATA_W-1:0];
  endfunction

  // ------------------------------
  // Valid alignment
  // ------------------------------
  // LATENCY core stages plus the lane adder
  logic [LATENCY:0] vld_sr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[LATENCY-1:0], ops.valid};
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------
  // Payload, no reset
  always_ff @(posedge clk) begin
    res_word.fields.re <= round_sat(re_sum);
    res_word.fields.im <= round_sat(im_sum);
  end

  // Strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= vld_sr[LATENCY];
    end
  end

  // Quiet right after any reset cycle
  a_quiet_after_reset : assert property (
    @(posedge clk) !rst_n |=> !out_valid
  ) else $error("cmult_round: out_valid high after reset");

  // Strobe always defined outside reset
  a_valid_known : assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
  ) else $error("cmult_round: out_valid unknown");

endmodule

//--- source/cmult_top.sv
// Streaming Q1.15 complex multiplier top level, plain valid-strobe ports for the testbench

`timescale 1ns/10ps

module cmult_top
  import cmult_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [2*DATA_W-1:0] a_word,
  input  logic [2*DATA_W-1:0] b_word,
  output logic [2*DATA_W-1:0] res_word,
  output logic                out_valid
);

  // ------------------------------
  // Operand unpack
  // ------------------------------
  cplx_word_u a_u;
  cplx_word_u b_u;
  cplx_word_u res_u;

  assign a_u.raw = a_word;
  assign b_u.raw = b_word;

  cmult_operand_if ops ();

  assign ops.a_re  = a_u.fields.re;
  assign ops.a_im  = a_u.fields.im;
  assign ops.b_re  = b_u.fields.re;
  assign ops.b_im  = b_u.fields.im;
  assign ops.valid = in_valid;

  // ------------------------------
  // Lanes
  // ------------------------------
  logic signed [SUM_W-1:0] re_sum;
  logic signed [SUM_W-1:0] im_sum;

  // ar*br - ai*bi
  cmult_lane #(.SUBTRACT(1'b1), .IN_PIPE(1'b0), .OP_W(DATA_W)) re_lane (
    .clk   (clk),
    .x0    (ops.a_re),
    .y0    (ops.b_re),
    .x1    (ops.a_im),
    .y1    (ops.b_im),
    .valid (ops.valid),
    .sum   (re_sum)
  );

  // ar*bi + ai*br
  cmult_lane #(.SUBTRACT(1'b0), .IN_PIPE(1'b0), .OP_W(DATA_W)) im_lane (
    .clk   (clk),
    .x0    (ops.a_re),
    .y0    (ops.b_im),
    .x1    (ops.a_im),
    .y1    (ops.b_re),
    .valid (ops.valid),
    .sum   (im_sum)
  );

  // Round, clamp, pack
  cmult_round combiner (
    .clk       (clk),
    .rst_n     (rst_n),
    .ops       (ops),
    .re_sum    (re_sum),
    .im_sum    (im_sum),
    .res_word  (res_u),
    .out_valid (out_valid)
  );

  assign res_word = res_u.raw;

endmodule

//--- testbench/cmult_tb.sv
// Self-checking testbench for the complex multiplier, stimulus and expected words from the vector file

`timescale 1ns/10ps

module cmult_tb
  import cmult_pkg::*;
();

  // Issue to result, core plus adder plus output register
  localparam int    PIPE_DELAY = LATENCY + 2;
  localparam string VEC_FILE   = "testbench/cmult_vectors.txt";

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic [2*DATA_W-1:0] a_word;
  logic [2*DATA_W-1:0] b_word;
  logic [2*DATA_W-1:0] res_word;
  logic                out_valid;

  // Vector table, one entry per data line
  cplx_word_u vec_a[$];
  cplx_word_u vec_b[$];
  bit         vec_v[$];
  cplx_word_u vec_e[$];
  string      vec_name[$];

  // Results in flight, oldest first
  cplx_word_u exp_q[$];
  int         issue_q[$];
  string      name_q[$];

  int cyc         = 0;
  int run_cycles  = 0;
  int cycle_limit = 0;

  cmult_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a_word    (a_word),
    .b_word    (b_word),
    .res_word  (res_word),
    .out_valid (out_valid)
  );

  // ------------------------------
  // Clock and cycle count
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Edge number, read mid-cycle
  always @(posedge clk) cyc <= cyc + 1;

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input cplx_word_u expected,
                            input cplx_word_u actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %h actual %h", name, expected.raw, actual.raw));
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      abort_run($sformatf("error: %s latency expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // ------------------------------
  // Vector file
  // ------------------------------
  task automatic load_vectors();
    int        fd;
    int        n;
    int        v;
    string     line;
    string     name;
    bit [31:0] a;
    bit [31:0] b;
    bit [31:0] e;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      abort_run({"could not open the vector file ", VEC_FILE});
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Column header and blank lines
        if (line.len() < 2 || line.substr(0, 1) == "//") continue;
        n = $sscanf(line, "%h %h %h %h %s", a, b, v, e, name);
        if (n == 5) begin
          vec_a.push_back(cplx_word_u'(a));
          vec_b.push_back(cplx_word_u'(b));
          vec_v.push_back(v != 0);
          vec_e.push_back(cplx_word_u'(e));
          vec_name.push_back(name);
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // Result monitor, sampled mid-cycle
  // ------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      if (cyc > 0 && out_valid !== 1'b0) abort_run("out_valid was not low during reset");
    end else if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("out_valid went high with no result outstanding");
      end else begin
        check_latency(name_q[0], PIPE_DELAY, cyc - issue_q[0]);
        check_word(name_q[0], exp_q[0], cplx_word_u'(res_word));
        void'(exp_q.pop_front());
        void'(issue_q.pop_front());
        void'(name_q.pop_front());
      end
    end else if (out_valid !== 1'b0) begin
      abort_run("out_valid was unknown after reset");
    end
  end

  // Run length guard, counted from reset release
  always @(posedge clk) begin
    if (rst_n) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles > cycle_limit) abort_run("timeout, results did not drain in time");
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    int idle;
    int drain_wait;
    void'($urandom(32'h6789_34aa));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a_word   = '0;
    b_word   = '0;
    load_vectors();
    // Up to 4 random idles per vector, then drain and margin
    cycle_limit = vec_v.size() * 5 + PIPE_DELAY + 20;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    foreach (vec_v[i]) begin
      @(posedge clk);
      a_word   <= vec_a[i].raw;
      b_word   <= vec_b[i].raw;
      in_valid <= vec_v[i];
      if (vec_v[i]) begin
        exp_q.push_back(vec_e[i]);
        issue_q.push_back(cyc + 1);
        name_q.push_back(vec_name[i]);
      end else begin
        // Stretch the gap between bursts
        idle = $urandom_range(4, 0);
        repeat (idle) @(posedge clk);
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;

    // Last results are due within one pipeline delay
    drain_wait = 0;
    while (exp_q.size() != 0 && drain_wait <= PIPE_DELAY) begin
      @(posedge clk);
      drain_wait++;
    end
    // Extra window for stray strobes
    repeat (PIPE_DELAY) @(posedge clk);

    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d results never came out", exp_q.size()));
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- testbench/cmult_vectors.txt
// a_word b_word valid expected name, hex, real part in the upper 16 bits (Q1.15)
// expected is ignored on lines with valid 0, which are idle cycles between bursts
40002000 4000c000 1 3000f000 exact_half_quarter
01000200 0080ff80 1 00030001 exact_small
00000000 00000000 0 00000000 idle
00010000 40004000 1 00010001 round_tie_up
00010000 3fff4000 1 00000001 round_below_half
ffff0000 40000000 1 00000000 round_neg_tie
ffff0000 40010000 1 ffff0000 round_neg_below
00000000 00000000 0 00000000 idle
80000000 80000000 1 7fff0000 sat_minus_one_squared
80008000 80007fff 1 7fff0001 sat_re_pos
80008000 80008000 1 00007fff sat_im_pos
80007fff 7fff7fff 1 8000ffff sat_re_neg
7fff8000 80008000 1 80000001 sat_re_neg_b
00000000 00000000 0 00000000 idle
20002000 20002000 1 00001000 stream_a
40000000 40000000 1 20000000 stream_b
00004000 00004000 1 e0000000 stream_c
00000000 00000000 0 00000000 idle
7fff0000 7fff0000 1 7ffe0000 stream_d
00030005 20006000 1 fffd0004 stream_e
0100ff00 01000100 1 00040000 stream_f
c0004000 c000c000 1 40000000 stream_g
00000000 00000000 0 00000000 idle
00010001 00010001 1 00000000 stream_h
40002000 4000c000 1 3000f000 stream_i
80000000 80000000 1 7fff0000 stream_j

//--- sim.f
source/cmult_pkg.sv
source/arith_mult_core.sv
source/cmult_operand_if.sv
source/cmult_lane.sv
source/cmult_round.sv
source/cmult_top.sv
testbench/cmult_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the complex multiplier testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cmult_tb -f sim.f -o cmult_sim \
  && ./obj_dir/cmult_sim 2>&1 | tee sim.log \
  || { echo "build or run did not complete"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass line found in sim.log"; exit 1; }
exit 0
